//--- logic/pmtrdt_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing of the compare/reduction/permutation cluster
// element width and count are fixed, no vl or masking
// RS_DEPTH and LANE_CREDITS must be powers of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PMTRDT_MACROS_SVH
`define PMTRDT_MACROS_SVH

// identical execution lanes
`define NUM_LANES 3
// vector register and element width
`define VLEN 128
`define ELEN 32
`define NUM_ELEM (`VLEN / `ELEN)
// reservation queue entries
`define RS_DEPTH 4
// result buffer slots per lane, also the reset credit count
`define LANE_CREDITS 2
// reorder buffer tag bits
`define TAG_W 4

`endif

//--- logic/pmtrdt_uop_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// micro-op types of the execution cluster
// element order in vreg_t is little endian, index 0 lowest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pmtrdt_macros.svh"

package pmtrdt_uop_pkg;

  // compare, reduction and permutation opcodes
  typedef enum logic [2:0] {
    // compares, result is a 4-bit mask
    op_cmp_eq         = 3'd0,
    op_cmp_lt         = 3'd1,
    op_cmp_ltu        = 3'd2,
    // reductions seeded by vs1 element 0
    op_rdt_sum        = 3'd3,
    op_rdt_max        = 3'd4,
    op_rdt_and        = 3'd5,
    // permutations
    op_pmt_compress   = 3'd6,
    op_pmt_slide1down = 3'd7
  } pmtrdt_op_e;

  // one element
  typedef logic [`ELEN-1:0] elem_t;

  // full register, element 0 in the low bits
  typedef elem_t [`NUM_ELEM-1:0] vreg_t;

  // reorder buffer tag
  typedef logic [`TAG_W-1:0] rob_tag_t;

  // micro-op as held in the reservation queue
  typedef struct packed {
    pmtrdt_op_e opcode;
    rob_tag_t   tag;
    // vs1 carries the seed, the compress mask or the slide-in element
    vreg_t      vs1;
    vreg_t      vs2;
  } pmtrdt_uop_t;

endpackage

//--- logic/pmtrdt_res_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result types of the execution cluster
// unused bits of mask and scalar results are zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pmtrdt_res_pkg;

  // layout of the data field
  typedef enum logic [1:0] {
    // mask in bits 3..0
    res_mask   = 2'd0,
    // scalar in element 0
    res_scalar = 2'd1,
    // all four elements
    res_vector = 2'd2
  } res_kind_e;

  // one completed micro-op towards the reorder buffer
  typedef struct packed {
    pmtrdt_uop_pkg::rob_tag_t tag;
    res_kind_e                kind;
    pmtrdt_uop_pkg::vreg_t    data;
  } pmtrdt_res_t;

endpackage

//--- logic/pmtrdt_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane-side links of the cluster, no ready signals
// flow is bounded by credits held in the dispatcher
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

// dispatcher to one lane, the lane accepts every beat
interface pmtrdt_issue_if;
  import pmtrdt_uop_pkg::*;

  logic       valid;
  pmtrdt_op_e opcode;
  rob_tag_t   tag;
  vreg_t      vs1;
  vreg_t      vs2;

  modport source (output valid, opcode, tag, vs1, vs2);
  modport sink   (input  valid, opcode, tag, vs1, vs2);
endinterface

// one lane to writeback, a free slot is always there
interface pmtrdt_result_if;
  import pmtrdt_uop_pkg::*;
  import pmtrdt_res_pkg::*;

  logic      valid;
  rob_tag_t  tag;
  res_kind_e kind;
  vreg_t     data;

  modport source (output valid, tag, kind, data);
  modport sink   (input  valid, tag, kind, data);
endinterface

//--- logic/pmtrdt_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reservation queue and credit-based lane issue
// at most one issue per cycle, round robin over lanes
// an accepted uop issues one cycle later at the earliest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pmtrdt_macros.svh"

module pmtrdt_dispatch (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       uop_valid,
  output logic                       uop_ready,
  input  pmtrdt_uop_pkg::pmtrdt_uop_t uop,
  pmtrdt_issue_if.source             issue [`NUM_LANES-1:0],
  input  logic [`NUM_LANES-1:0]      credit_return
);
  import pmtrdt_uop_pkg::*;

  localparam int NL    = `NUM_LANES;
  localparam int DEPTH = `RS_DEPTH;
  localparam int LC    = `LANE_CREDITS;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(LC + 1);
  localparam int LW    = (NL > 1) ? $clog2(NL) : 1;

  // circular queue
  pmtrdt_uop_t   q_mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          push;
  logic          pop;
  pmtrdt_uop_t   head;

  // free result slots per lane
  logic [CW-1:0] credit [NL];
  logic [LW-1:0] rr_ptr;
  logic [LW-1:0] sel_lane;
  logic          sel_found;
  logic [NL-1:0] lane_fire;

  assign uop_ready = (count != (PW+1)'(DEPTH));
  assign push      = uop_valid && uop_ready;
  assign head      = q_mem[rd_ptr];
  // head leaves once some lane has a free slot
  assign pop       = (count != '0) && sel_found;

  // first lane with credit, starting at the rr pointer
  always_comb begin : pick_lane
    int cand;
    sel_found = 1'b0;
    sel_lane  = '0;
    for (int k = 0; k < NL; k++) begin
      cand = (int'(rr_ptr) + k) % NL;
      if (!sel_found && credit[cand] != '0) begin
        sel_found = 1'b1;
        sel_lane  = LW'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rr_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        // next search starts after the lane just used
        rr_ptr <= (sel_lane == LW'(NL - 1)) ? '0 : sel_lane + 1'b1;
      end
      count <= count + (PW+1)'(push) - (PW+1)'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) q_mem[wr_ptr] <= uop;
  end

  // one slot back per drained result, one taken per issue
  always_ff @(posedge clk) begin
    for (int l = 0; l < NL; l++) begin
      if (rst) credit[l] <= CW'(LC);
      else credit[l] <= credit[l] + CW'(credit_return[l]) - CW'(lane_fire[l]);
    end
  end

  for (genvar l = 0; l < NL; l++) begin : gen_issue
    assign lane_fire[l]     = pop && (sel_lane == LW'(l));
    // payload is broadcast, only the valid is per lane
    assign issue[l].valid   = lane_fire[l];
    assign issue[l].opcode  = head.opcode;
    assign issue[l].tag     = head.tag;
    assign issue[l].vs1     = head.vs1;
    assign issue[l].vs2     = head.vs2;

    // writeback must never return more slots than were taken
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
      credit[l] <= CW'(LC)) else $error("lane %0d credit overflow", l);
    a_issue_credit: assert property (@(posedge clk) disable iff (rst)
      lane_fire[l] |-> credit[l] != '0) else $error("lane %0d issued without credit", l);
  end

  a_push_full: assert property (@(posedge clk) disable iff (rst)
    count == (PW+1)'(DEPTH) |-> !push) else $error("push into full queue");

endmodule

//--- logic/pmtrdt_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-stage compare/reduction/permutation lane
// fixed latency of two cycles, never stalls
// pairwise reduction tree assumes four elements
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pmtrdt_macros.svh"

module pmtrdt_lane (
  input  logic             clk,
  input  logic             rst,
  pmtrdt_issue_if.sink     issue,
  pmtrdt_result_if.source  result
);
  import pmtrdt_uop_pkg::*;
  import pmtrdt_res_pkg::*;

  localparam int NE = `NUM_ELEM;
  localparam int PW = $clog2(NE);

  // stage 1 registers
  logic                  s1_valid;
  pmtrdt_op_e            s1_op;
  rob_tag_t              s1_tag;
  elem_t                 s1_seed;
  logic [NE-1:0]         s1_cmp;
  logic [NE-1:0]         s1_mask;
  elem_t [1:0]           s1_part;
  logic [NE-1:0][PW-1:0] s1_pos;
  vreg_t                 s1_vec;

  // stage 1 next values
  logic [NE-1:0]         c_cmp;
  elem_t [1:0]           c_part;
  logic [NE-1:0][PW-1:0] c_pos;
  vreg_t                 c_vec;

  // stage 2
  res_kind_e c_kind;
  vreg_t     c_data;
  logic      r_valid;
  rob_tag_t  r_tag;
  res_kind_e r_kind;
  vreg_t     r_data;

  // one reduction step, and is the fallback
  function automatic elem_t fold(pmtrdt_op_e op, elem_t a, elem_t b);
    case (op)
      op_rdt_sum: return a + b;
      op_rdt_max: return ($signed(a) > $signed(b)) ? a : b;
      default:    return a & b;
    endcase
  endfunction

  // stage 1: compares, partials, compress positions, slide
  always_comb begin : stage1
    logic [PW-1:0] run;
    run = '0;
    for (int i = 0; i < NE; i++) begin
      case (issue.opcode)
        op_cmp_lt:  c_cmp[i] = $signed(issue.vs2[i]) < $signed(issue.vs1[i]);
        op_cmp_ltu: c_cmp[i] = issue.vs2[i] < issue.vs1[i];
        default:    c_cmp[i] = issue.vs2[i] == issue.vs1[i];
      endcase
      // destination slot = set mask bits below i
      c_pos[i] = run;
      run      = run + PW'(issue.vs1[0][i]);
    end
    c_part[0] = fold(issue.opcode, issue.vs2[0], issue.vs2[1]);
    c_part[1] = fold(issue.opcode, issue.vs2[2], issue.vs2[3]);
    c_vec     = issue.vs2;
    if (issue.opcode == op_pmt_slide1down) begin
      for (int i = 0; i < NE - 1; i++) begin
        c_vec[i] = issue.vs2[i+1];
      end
      // vs1 element 0 enters at the top
      c_vec[NE-1] = issue.vs1[0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) s1_valid <= 1'b0;
    else s1_valid <= issue.valid;
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      s1_op   <= issue.opcode;
      s1_tag  <= issue.tag;
      s1_seed <= issue.vs1[0];
      s1_mask <= issue.vs1[0][NE-1:0];
      s1_cmp  <= c_cmp;
      s1_part <= c_part;
      s1_pos  <= c_pos;
      s1_vec  <= c_vec;
    end
  end

  // stage 2: final fold, compress packing, zero fill
  always_comb begin
    c_data = '0;
    c_kind = res_vector;
    case (s1_op)
      op_cmp_eq, op_cmp_lt, op_cmp_ltu: begin
        c_kind            = res_mask;
        c_data[0][NE-1:0] = s1_cmp;
      end
      op_rdt_sum, op_rdt_max, op_rdt_and: begin
        c_kind    = res_scalar;
        c_data[0] = fold(s1_op, s1_seed, fold(s1_op, s1_part[0], s1_part[1]));
      end
      op_pmt_compress: begin
        for (int i = 0; i < NE; i++) begin
          if (s1_mask[i]) c_data[s1_pos[i]] = s1_vec[i];
        end
      end
      // slide was already shifted in stage 1
      default: c_data = s1_vec;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) r_valid <= 1'b0;
    else r_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      r_tag  <= s1_tag;
      r_kind <= c_kind;
      r_data <= c_data;
    end
  end

  assign result.valid = r_valid;
  assign result.tag   = r_tag;
  assign result.kind  = r_kind;
  assign result.data  = r_data;

  a_latency: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> ##2 result.valid) else $error("lane latency is not two cycles");
  a_opcode: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> issue.opcode inside {op_cmp_eq, op_cmp_lt, op_cmp_ltu, op_rdt_sum,
                                         op_rdt_max, op_rdt_and, op_pmt_compress,
                                         op_pmt_slide1down})
    else $error("illegal opcode at lane input");

endmodule

//--- logic/pmtrdt_writeback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-lane result buffers draining into one port
// the offered lane is held until it is taken
// credit_return pulses in the cycle of the transfer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pmtrdt_macros.svh"

module pmtrdt_writeback (
  input  logic                         clk,
  input  logic                         rst,
  pmtrdt_result_if.sink                result [`NUM_LANES-1:0],
  output logic                         res_valid,
  input  logic                         res_ready,
  output pmtrdt_res_pkg::pmtrdt_res_t  res,
  output logic [`NUM_LANES-1:0]        credit_return
);
  import pmtrdt_res_pkg::*;

  localparam int NL = `NUM_LANES;
  localparam int LC = `LANE_CREDITS;
  localparam int AW = (LC > 1) ? $clog2(LC) : 1;
  localparam int CW = $clog2(LC + 1);
  localparam int LW = (NL > 1) ? $clog2(NL) : 1;

  logic [NL-1:0] in_valid;
  pmtrdt_res_t   in_res [NL];

  // one small FIFO per lane
  pmtrdt_res_t   buf_mem [NL][LC];
  logic [AW-1:0] wr_ptr [NL];
  logic [AW-1:0] rd_ptr [NL];
  logic [CW-1:0] fill [NL];
  logic [NL-1:0] not_empty;

  logic [LW-1:0] rr_ptr;
  logic [LW-1:0] pick_lane;
  logic          pick_found;
  logic [LW-1:0] sel_lane;
  logic          held;
  logic [LW-1:0] held_lane;
  logic          fire;

  for (genvar l = 0; l < NL; l++) begin : gen_lane_in
    assign in_valid[l]      = result[l].valid;
    assign in_res[l]        = '{tag: result[l].tag, kind: result[l].kind,
                                data: result[l].data};
    assign not_empty[l]     = (fill[l] != '0);
    assign credit_return[l] = fire && (sel_lane == LW'(l));

    a_push_full: assert property (@(posedge clk) disable iff (rst)
      in_valid[l] |-> fill[l] != CW'(LC)) else $error("lane %0d buffer overrun", l);
  end

  // first non-empty buffer from the rr pointer
  always_comb begin : pick
    int cand;
    pick_found = 1'b0;
    pick_lane  = '0;
    for (int k = 0; k < NL; k++) begin
      cand = (int'(rr_ptr) + k) % NL;
      if (!pick_found && not_empty[cand]) begin
        pick_found = 1'b1;
        pick_lane  = LW'(cand);
      end
    end
  end

  // a stalled offer keeps its lane even if another fills up
  assign sel_lane  = held ? held_lane : pick_lane;
  assign res_valid = pick_found;
  assign res       = buf_mem[sel_lane][rd_ptr[sel_lane]];
  assign fire      = res_valid && res_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      held      <= 1'b0;
      held_lane <= '0;
      rr_ptr    <= '0;
    end else begin
      held      <= res_valid && !res_ready;
      held_lane <= sel_lane;
      if (fire) rr_ptr <= (sel_lane == LW'(NL - 1)) ? '0 : sel_lane + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NL; l++) begin
      if (rst) begin
        wr_ptr[l] <= '0;
        rd_ptr[l] <= '0;
        fill[l]   <= '0;
      end else begin
        if (in_valid[l]) wr_ptr[l] <= wr_ptr[l] + 1'b1;
        if (credit_return[l]) rd_ptr[l] <= rd_ptr[l] + 1'b1;
        fill[l] <= fill[l] + CW'(in_valid[l]) - CW'(credit_return[l]);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NL; l++) begin
      if (in_valid[l]) buf_mem[l][wr_ptr[l]] <= in_res[l];
    end
  end

  a_res_stable: assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else $error("result port changed while stalled");

endmodule

//--- logic/pmtrdt_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare/reduction/permutation execution cluster
// valid/ready on both ports, results leave out of order
// minimum uop-to-result latency is four cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pmtrdt_macros.svh"

module pmtrdt_top (
  input  logic                       clk,
  input  logic                       rst,
  // micro-op port
  input  logic                       uop_valid,
  output logic                       uop_ready,
  input  pmtrdt_uop_pkg::pmtrdt_op_e uop_opcode,
  input  pmtrdt_uop_pkg::rob_tag_t   uop_tag,
  input  pmtrdt_uop_pkg::vreg_t      uop_vs1,
  input  pmtrdt_uop_pkg::vreg_t      uop_vs2,
  // result port
  output logic                       res_valid,
  input  logic                       res_ready,
  output pmtrdt_uop_pkg::rob_tag_t   res_tag,
  output pmtrdt_res_pkg::res_kind_e  res_kind,
  output pmtrdt_uop_pkg::vreg_t      res_data
);
  import pmtrdt_uop_pkg::*;
  import pmtrdt_res_pkg::*;

  pmtrdt_uop_t            uop;
  pmtrdt_res_t            res;
  logic [`NUM_LANES-1:0]  credit_return;

  pmtrdt_issue_if  issue_if  [`NUM_LANES-1:0] ();
  pmtrdt_result_if result_if [`NUM_LANES-1:0] ();

  assign uop = '{opcode: uop_opcode, tag: uop_tag, vs1: uop_vs1, vs2: uop_vs2};

  assign res_tag  = res.tag;
  assign res_kind = res.kind;
  assign res_data = res.data;

  pmtrdt_dispatch i_dispatch (
    .clk           (clk),
    .rst           (rst),
    .uop_valid     (uop_valid),
    .uop_ready     (uop_ready),
    .uop           (uop),
    .issue         (issue_if),
    .credit_return (credit_return)
  );

  // identical lanes, each with its own credit pool
  for (genvar l = 0; l < `NUM_LANES; l++) begin : gen_lane
    pmtrdt_lane i_lane (
      .clk    (clk),
      .rst    (rst),
      .issue  (issue_if[l]),
      .result (result_if[l])
    );
  end

  pmtrdt_writeback i_writeback (
    .clk           (clk),
    .rst           (rst),
    .result        (result_if),
    .res_valid     (res_valid),
    .res_ready     (res_ready),
    .res           (res),
    .credit_return (credit_return)
  );

endmodule

//--- dv/pmtrdt_ref_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expected results of one micro-op, element by element
// include inside a module that imports both packages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PMTRDT_REF_MODEL_SVH
`define PMTRDT_REF_MODEL_SVH

// layout of the data field per opcode class
function automatic res_kind_e expected_kind(pmtrdt_op_e op);
  case (op)
    op_cmp_eq, op_cmp_lt, op_cmp_ltu: return res_mask;
    op_rdt_sum, op_rdt_max, op_rdt_and: return res_scalar;
    default: return res_vector;
  endcase
endfunction

// data field, unused bits and elements stay zero
function automatic vreg_t expected_data(pmtrdt_op_e op, vreg_t vs1, vreg_t vs2);
  vreg_t d;
  elem_t acc;
  int    slot;
  d    = '0;
  acc  = vs1[0];
  slot = 0;
  for (int i = 0; i < `NUM_ELEM; i++) begin
    case (op)
      // bit i compares vs2 element i against vs1 element i
      op_cmp_eq:  d[0][i] = (vs2[i] == vs1[i]);
      op_cmp_lt:  d[0][i] = ($signed(vs2[i]) < $signed(vs1[i]));
      op_cmp_ltu: d[0][i] = (vs2[i] < vs1[i]);
      // running fold, seed is vs1 element 0
      op_rdt_sum: acc = acc + vs2[i];
      op_rdt_max: if ($signed(vs2[i]) > $signed(acc)) acc = vs2[i];
      op_rdt_and: acc = acc & vs2[i];
      // selected elements packed downwards in order
      op_pmt_compress: begin
        if (vs1[0][i]) begin
          d[slot] = vs2[i];
          slot++;
        end
      end
      default: begin
        if (i == `NUM_ELEM - 1) d[i] = vs1[0];
        else d[i] = vs2[i+1];
      end
    endcase
  end
  if (op inside {op_rdt_sum, op_rdt_max, op_rdt_and}) d[0] = acc;
  return d;
endfunction

`endif

//--- dv/pmtrdt_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for the execution cluster
// random uops and res_ready stalls from a fixed seed
// at most 16 uops outstanding, so tags stay unique
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pmtrdt_macros.svh"

module pmtrdt_tb;
  import pmtrdt_uop_pkg::*;
  import pmtrdt_res_pkg::*;

  `include "pmtrdt_ref_model.svh"

  localparam int N_OPS        = 300;
  localparam int MAX_OUT      = 16;
  // uop_ready may stay low this long after the last stall
  localparam int READY_WINDOW = 100;
  localparam int TIMEOUT_CYC  = N_OPS * 40 + 1000;
  localparam logic [31:0] SEED = 32'ha0be;

  logic       clk;
  logic       rst;
  logic       uop_valid;
  logic       uop_ready;
  pmtrdt_op_e uop_opcode;
  rob_tag_t   uop_tag;
  vreg_t      uop_vs1;
  vreg_t      uop_vs2;
  logic       res_valid;
  logic       res_ready;
  rob_tag_t   res_tag;
  res_kind_e  res_kind;
  vreg_t      res_data;

  // scoreboard indexed by tag
  logic      sb_busy [16];
  res_kind_e sb_kind [16];
  vreg_t     sb_data [16];

  int          n_sent;
  int          n_recv;
  int          err_mismatch;
  int          err_protocol;
  int          err_missing;
  logic [31:0] rng_uop;
  logic [31:0] rng_rdy;

  // result port as seen at the last edge
  logic      stalled;
  rob_tag_t  held_tag;
  res_kind_e held_kind;
  vreg_t     held_data;
  int        since_stall;

  pmtrdt_top i_pmtrdt_top (
    .clk        (clk),
    .rst        (rst),
    .uop_valid  (uop_valid),
    .uop_ready  (uop_ready),
    .uop_opcode (uop_opcode),
    .uop_tag    (uop_tag),
    .uop_vs1    (uop_vs1),
    .uop_vs2    (uop_vs2),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_tag    (res_tag),
    .res_kind   (res_kind),
    .res_data   (res_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_tag(string name, rob_tag_t got, rob_tag_t exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_kind(string name, res_kind_e got, res_kind_e exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_data(string name, vreg_t got, vreg_t exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d mismatches, %0d protocol, %0d missing", err_mismatch,
             err_protocol, err_missing);
  endtask

  // random stretches of res_ready, low ones up to 30 cycles
  task automatic drive_ready();
    int len;
    forever begin
      rng_rdy   = xorshift32(rng_rdy);
      len       = 1 + (int'(rng_rdy[4:0]) % 30);
      res_ready = (rng_rdy[7:5] >= 3'd3);
      repeat (len) next_cycle();
    end
  endtask

  task automatic drive_uops();
    logic [31:0] eq_bits;
    int          gap;
    rob_tag_t    tag;
    logic        accepted;
    tag = '0;
    for (int n = 0; n < N_OPS; n++) begin
      rng_uop = xorshift32(rng_uop);
      gap     = int'(rng_uop[1:0]);
      repeat (gap) next_cycle();
      // tag reuse only after its result came back
      while (n_sent - n_recv >= MAX_OUT) next_cycle();
      rng_uop    = xorshift32(rng_uop);
      uop_opcode = pmtrdt_op_e'(rng_uop[2:0]);
      eq_bits    = rng_uop;
      for (int i = 0; i < `NUM_ELEM; i++) begin
        rng_uop    = xorshift32(rng_uop);
        uop_vs1[i] = rng_uop;
        rng_uop    = xorshift32(rng_uop);
        uop_vs2[i] = rng_uop;
        // about half the compared elements equal
        if (uop_opcode inside {op_cmp_eq, op_cmp_lt, op_cmp_ltu} && eq_bits[8+i])
          uop_vs2[i] = uop_vs1[i];
      end
      uop_tag   = tag;
      uop_valid = 1'b1;
      accepted  = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = uop_ready;
        #1;
      end
      sb_busy[tag] = 1'b1;
      sb_kind[tag] = expected_kind(uop_opcode);
      sb_data[tag] = expected_data(uop_opcode, uop_vs1, uop_vs2);
      n_sent++;
      tag++;
      uop_valid = 1'b0;
    end
  endtask

  // result port monitor, sampled at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (stalled) begin
        if (!res_valid) begin
          err_protocol++;
          $display("%0t: res_valid dropped before the result was taken", $time);
        end
        check_tag("res_tag", res_tag, held_tag);
        check_kind("res_kind", res_kind, held_kind);
        check_data("res_data", res_data, held_data);
      end
      if (res_valid && res_ready) begin
        if (!sb_busy[res_tag]) begin
          err_protocol++;
          $display("%0t: result for tag %0d which has no outstanding micro-op", $time,
                   res_tag);
        end else begin
          check_kind("res_kind", res_kind, sb_kind[res_tag]);
          check_data("res_data", res_data, sb_data[res_tag]);
          sb_busy[res_tag] = 1'b0;
        end
        n_recv++;
      end
      stalled   = res_valid && !res_ready;
      held_tag  = res_tag;
      held_kind = res_kind;
      held_data = res_data;
      // queue full only after results were withheld
      if (!res_ready) since_stall = 0;
      else if (since_stall <= READY_WINDOW) since_stall++;
      if (!uop_ready && since_stall > READY_WINDOW) begin
        err_protocol++;
        $display("%0t: uop_ready low although no result was withheld for %0d cycles",
                 $time, READY_WINDOW);
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    report_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    rst          = 1'b1;
    uop_valid    = 1'b0;
    uop_opcode   = op_cmp_eq;
    uop_tag      = '0;
    uop_vs1      = '0;
    uop_vs2      = '0;
    res_ready    = 1'b0;
    n_sent       = 0;
    n_recv       = 0;
    err_mismatch = 0;
    err_protocol = 0;
    err_missing  = 0;
    rng_uop      = SEED;
    // second stream, decoupled from the uop one
    rng_rdy      = xorshift32(SEED ^ 32'h5a5a_0000);
    stalled      = 1'b0;
    since_stall  = 0;
    for (int t = 0; t < 16; t++) sb_busy[t] = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    if (res_valid !== 1'b0) begin
      err_protocol++;
      $display("%0t: res_valid is not low after reset", $time);
    end
    if (uop_ready !== 1'b1) begin
      err_protocol++;
      $display("%0t: uop_ready is not high after reset", $time);
    end
    fork
      drive_ready();
    join_none
    drive_uops();
    for (int c = 0; c < 2000 && n_recv < N_OPS; c++) next_cycle();
    // late duplicates still get caught here
    repeat (20) next_cycle();
    for (int t = 0; t < 16; t++) begin
      if (sb_busy[t]) begin
        err_missing++;
        $display("no result arrived for tag %0d", t);
      end
    end
    if (n_recv != N_OPS) begin
      err_missing++;
      $display("received %0d results for %0d micro-ops", n_recv, N_OPS);
    end
    report_counts();
    if (err_mismatch + err_protocol + err_missing == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+logic
+incdir+dv
logic/pmtrdt_uop_pkg.sv
logic/pmtrdt_res_pkg.sv
logic/pmtrdt_if.sv
logic/pmtrdt_dispatch.sv
logic/pmtrdt_lane.sv
logic/pmtrdt_writeback.sv
logic/pmtrdt_top.sv
dv/pmtrdt_tb.sv

//--- Makefile
# Verilator build and run of the pmtrdt testbench

VERILATOR  ?= verilator
TOP        := pmtrdt_tb
FILELIST   := compile.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, a crash without the pass line also fails
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module pmtrdt_top -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
